// File: source/motion_ctrl_pkg.sv
// Motion control definitions shared by the step generator and its testbench
package motion_ctrl_pkg;

  // Host word layout
  localparam int word_bits   = 64;
  localparam int header_bits = 8;  // Taken from the top of each word

  // Command headers
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_status_reg       = 8'hf1;
  localparam logic [7:0] cmd_config_reg       = 8'hf2;

  // Config header bit that announces a data word to follow
  localparam int config_write_bit = 8;

  // Field widths
  localparam int dda_frac_bits = 32;  // One step per 2**dda_frac_bits of accumulated rate
  localparam int duration_bits = 32;
  localparam int position_bits = 32;
  localparam int divisor_bits  = 8;

  // Status addresses, read only
  localparam int status_version        = 0;
  localparam int status_channel_info   = 1;
  localparam int status_position_start = 2;  // Motor m at 2+m

  // Config addresses
  localparam int config_enable = 0;
  localparam int config_clocks = 1;

  // Constant version word
  localparam logic [31:0] version_word = 32'h0001_0300;

  // Reset values
  localparam int default_clock_divisor = 32;

endpackage

// File: source/dda_axis.sv
`timescale 1ns/1ps
// DDA axis: integrates rate and acceleration per tick and emits steps with a position count
module dda_axis (
  input  logic                                      CLK,
  input  logic                                      resetn,
  input  logic                                      dda_tick,
  input  logic                                      load,
  input  logic                                      executing,
  input  logic [motion_ctrl_pkg::dda_frac_bits-1:0] rate,
  input  logic [motion_ctrl_pkg::dda_frac_bits-1:0] accel,
  input  logic                                      move_dir,
  output logic                                      step,
  output logic signed [motion_ctrl_pkg::position_bits-1:0] position
);

  localparam int frac_bits = motion_ctrl_pkg::dda_frac_bits;

  logic [frac_bits-1:0] accel_sum;  // Rate gained since load
  logic [frac_bits-1:0] accum;
  logic [frac_bits-1:0] next_sum;
  logic [frac_bits-1:0] velocity;
  logic [frac_bits:0]   accum_next;

  // Acceleration first, then the new rate into the accumulator
  assign next_sum   = accel_sum + accel;
  assign velocity   = rate + next_sum;
  assign accum_next = {1'b0, accum} + {1'b0, velocity};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accel_sum <= '0;
      accum     <= '0;
      step      <= 1'b0;
      position  <= '0;
    end else begin
      step <= 1'b0;
      if (load) begin
        accel_sum <= '0;
        accum     <= '0;
      end else if (executing && dda_tick) begin
        accel_sum <= next_sum;
        accum     <= accum_next[frac_bits-1:0];
        step      <= accum_next[frac_bits];  // Carry out of the fraction
        if (accum_next[frac_bits]) begin
          position <= move_dir ? position + 1'b1 : position - 1'b1;
        end
      end
    end
  end

  // Steps belong to a running move, the last one lands as executing falls
  assert property (@(posedge CLK) disable iff (resetn)
    step |-> executing || $past(executing))
    else $error("step outside a move");

endmodule

// File: source/move_sequencer.sv
`timescale 1ns/1ps
// Move sequencer: DDA tick divider and the load/execute cycle of buffered moves
module move_sequencer (
  input  logic                                      CLK,
  input  logic                                      resetn,
  input  logic [motion_ctrl_pkg::divisor_bits-1:0]  clock_divisor,
  input  logic                                      slot_ready,
  input  logic [motion_ctrl_pkg::duration_bits-1:0] duration,
  output logic                                      dda_tick,
  output logic                                      load,
  output logic                                      executing,
  output logic                                      release_slot,
  output logic                                      move_done
);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_exec,
    st_done
  } state_t;

  state_t                                    state;
  logic [motion_ctrl_pkg::divisor_bits-1:0]  div_count;
  logic [motion_ctrl_pkg::divisor_bits-1:0]  div_last;
  logic [motion_ctrl_pkg::duration_bits-1:0] tick_count;

  // Divisor 0 runs like 1
  assign div_last = (clock_divisor == '0) ? '0 : clock_divisor - 1'b1;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= '0;
      dda_tick  <= 1'b0;
    end else begin
      dda_tick <= (div_count >= div_last);
      if (div_count >= div_last) div_count <= '0;  // Also catches a lowered divisor
      else div_count <= div_count + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= st_idle;
      tick_count <= '0;
    end else begin
      case (state)
        st_idle: if (slot_ready) state <= st_load;
        st_load: begin
          tick_count <= '0;
          state      <= (duration == '0) ? st_done : st_exec;
        end
        st_exec: begin
          if (dda_tick) begin
            tick_count <= tick_count + 1'b1;
            if (tick_count == duration - 1'b1) state <= st_done;  // Last counted tick
          end
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  assign load         = (state == st_load);
  assign executing    = (state == st_exec);
  assign move_done    = (state == st_done);
  assign release_slot = (state == st_done);

  // Done is a single pulse and the move has stopped by then
  assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done && !executing)
    else $error("move_done wider than one cycle");

endmodule

// File: source/move_buffer.sv
`timescale 1ns/1ps
// Move buffer: slot storage for queued moves with a ready flag per slot
module move_buffer #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   wr_en,
  input  logic [$clog2(buffer_size)-1:0]         wr_slot,
  input  logic [$clog2(2*num_motors+2)-1:0]      wr_index,
  input  logic [motion_ctrl_pkg::word_bits-1:0]  wr_data,
  input  logic [num_motors-1:0]                  wr_dir,
  input  logic                                   commit,
  input  logic                                   release_slot,
  output logic                                   full,
  output logic                                   slot_ready,
  output logic                                   buffer_dtr,
  output logic [motion_ctrl_pkg::duration_bits-1:0] duration,
  output logic [num_motors-1:0]                  move_dir,
  output logic [num_motors-1:0][motion_ctrl_pkg::dda_frac_bits-1:0] rate,
  output logic [num_motors-1:0][motion_ctrl_pkg::dda_frac_bits-1:0] accel
);

  localparam int frac_bits = motion_ctrl_pkg::dda_frac_bits;

  if (buffer_size < 2 || (buffer_size & (buffer_size - 1)) != 0) begin : g_size_check
    $error("buffer_size must be a power of two, at least 2");
  end

  logic [motion_ctrl_pkg::duration_bits-1:0]  duration_mem [buffer_size];
  logic [num_motors-1:0]                      dir_mem      [buffer_size];
  logic [num_motors-1:0][frac_bits-1:0]       rate_mem     [buffer_size];
  logic [num_motors-1:0][frac_bits-1:0]       accel_mem    [buffer_size];
  logic [buffer_size-1:0]                     ready;
  logic [$clog2(buffer_size)-1:0]             read_slot;

  // Word 0 keeps the directions, word 1 the duration, then rate/accel pairs
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      if (wr_index == '0) dir_mem[wr_slot] <= wr_dir;
      if (wr_index == 1) duration_mem[wr_slot] <= wr_data[motion_ctrl_pkg::duration_bits-1:0];
      for (int m = 0; m < num_motors; m++) begin
        if (wr_index == 2 + 2 * m) rate_mem[wr_slot][m] <= wr_data[frac_bits-1:0];
        if (wr_index == 3 + 2 * m) accel_mem[wr_slot][m] <= wr_data[frac_bits-1:0];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      ready     <= '0;
      read_slot <= '0;
    end else begin
      if (commit) ready[wr_slot] <= 1'b1;
      if (release_slot) begin
        ready[read_slot] <= 1'b0;
        read_slot        <= read_slot + 1'b1;  // Wraps with power-of-two size
      end
    end
  end

  assign full       = &ready;
  assign buffer_dtr = ~full;
  assign slot_ready = ready[read_slot];

  // Read slot contents held until release
  assign duration = duration_mem[read_slot];
  assign move_dir = dir_mem[read_slot];
  assign rate     = rate_mem[read_slot];
  assign accel    = accel_mem[read_slot];

  assert property (@(posedge CLK) disable iff (resetn) release_slot |-> slot_ready)
    else $error("slot released while not ready");

endmodule

// File: source/command_decoder.sv
`timescale 1ns/1ps
// Command decoder: turns host words into move writes, status reads and config accesses
module command_decoder #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic [motion_ctrl_pkg::word_bits-1:0]  word_data_received,
  input  logic                                   word_received,
  input  logic                                   full,
  input  logic [num_motors-1:0][motion_ctrl_pkg::position_bits-1:0] position,
  output logic [motion_ctrl_pkg::word_bits-1:0]  word_send_data,
  output logic                                   wr_en,
  output logic [$clog2(buffer_size)-1:0]         wr_slot,
  output logic [$clog2(2*num_motors+2)-1:0]      wr_index,
  output logic [motion_ctrl_pkg::word_bits-1:0]  wr_data,
  output logic [num_motors-1:0]                  wr_dir,
  output logic                                   commit,
  output logic [motion_ctrl_pkg::divisor_bits-1:0] clock_divisor,
  output logic [num_motors-1:0]                  enable
);

  localparam int last_index = 2 * num_motors + 1;  // Last word of a move
  localparam int index_bits = $clog2(2 * num_motors + 2);
  localparam int word_bits  = motion_ctrl_pkg::word_bits;
  localparam int pos_bits   = motion_ctrl_pkg::position_bits;

  logic                                    word_received_q;
  logic                                    word_received_qq;
  logic                                    word_strobe;
  logic [motion_ctrl_pkg::header_bits-1:0] header;
  logic [motion_ctrl_pkg::header_bits-1:0] msg_header;  // Zero when no message is open
  logic [index_bits-1:0]                   word_count;
  logic [7:0]                              addr;
  logic [7:0]                              dma_addr;
  logic                                    dropping;  // Move arrived while full
  logic                                    awaiting;
  logic                                    move_word;
  logic [word_bits-1:0]                    status_word;
  logic [word_bits-1:0]                    config_word;

  assign word_strobe = word_received_q && !word_received_qq;
  assign header      = word_data_received[word_bits-1 -: motion_ctrl_pkg::header_bits];
  assign addr        = word_data_received[7:0];
  assign awaiting    = (msg_header != '0);

  // Move words go to the buffer unless the move is being swallowed
  assign move_word = awaiting ? (msg_header == motion_ctrl_pkg::cmd_coordinated_step && !dropping)
                              : (header == motion_ctrl_pkg::cmd_coordinated_step && !full);
  assign wr_en    = word_strobe && move_word;
  assign wr_index = awaiting ? word_count : '0;
  assign wr_data  = word_data_received;
  assign wr_dir   = word_data_received[num_motors-1:0];  // Only stored on the header
  assign commit   = wr_en && (wr_index == index_bits'(last_index));

  // Read-only status map
  always_comb begin
    status_word = '0;
    if (addr == 8'(motion_ctrl_pkg::status_version)) begin
      status_word[31:0] = motion_ctrl_pkg::version_word;
    end else if (addr == 8'(motion_ctrl_pkg::status_channel_info)) begin
      status_word[7:0]  = 8'(num_motors);
      status_word[15:8] = 8'(motion_ctrl_pkg::dda_frac_bits);
    end else begin
      for (int m = 0; m < num_motors; m++) begin
        if (addr == 8'(motion_ctrl_pkg::status_position_start + m)) begin
          status_word = {{(word_bits-pos_bits){position[m][pos_bits-1]}}, position[m]};
        end
      end
    end
  end

  always_comb begin
    config_word = '0;
    case (addr)
      8'(motion_ctrl_pkg::config_enable): config_word[num_motors-1:0] = enable;
      8'(motion_ctrl_pkg::config_clocks):
        config_word[motion_ctrl_pkg::divisor_bits-1:0] = clock_divisor;
      default: ;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q  <= 1'b0;
      word_received_qq <= 1'b0;
      word_send_data   <= '0;
      msg_header       <= '0;
      word_count       <= '0;
      dropping         <= 1'b0;
      wr_slot          <= '0;
      enable           <= '0;
      clock_divisor    <= motion_ctrl_pkg::divisor_bits'(motion_ctrl_pkg::default_clock_divisor);
    end else begin
      word_received_q  <= word_received;
      word_received_qq <= word_received_q;
      if (word_strobe) begin
        word_send_data <= '0;
        if (!awaiting) begin
          case (header)
            motion_ctrl_pkg::cmd_coordinated_step: begin
              msg_header <= header;
              word_count <= index_bits'(1);
              dropping   <= full;  // Whole move is lost if no slot is free
            end
            motion_ctrl_pkg::cmd_status_reg: word_send_data <= status_word;
            motion_ctrl_pkg::cmd_config_reg: begin
              word_send_data <= config_word;
              dma_addr       <= addr;
              if (word_data_received[motion_ctrl_pkg::config_write_bit]) begin
                msg_header <= header;  // Next word carries the data
              end
            end
            default: ;
          endcase
        end else if (msg_header == motion_ctrl_pkg::cmd_coordinated_step) begin
          word_count <= word_count + 1'b1;
          if (word_count == index_bits'(last_index)) begin
            msg_header <= '0;
            word_count <= '0;
            if (!dropping) begin
              wr_slot <= wr_slot + 1'b1;
            end
          end
        end else begin
          // Config data word
          if (dma_addr == 8'(motion_ctrl_pkg::config_enable)) begin
            enable <= word_data_received[num_motors-1:0];
          end else if (dma_addr == 8'(motion_ctrl_pkg::config_clocks)) begin
            clock_divisor <= word_data_received[motion_ctrl_pkg::divisor_bits-1:0];
          end
          msg_header <= '0;
        end
      end
    end
  end

  // A move is only committed into a slot that was free at its header
  assert property (@(posedge CLK) disable iff (resetn) commit |-> !full)
    else $error("move committed while buffer full");

endmodule

// File: source/motion_ctrl.sv
`timescale 1ns/1ps
// Multi-axis step generator commanded by host words
module motion_ctrl #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                                  CLK,
  input  logic                                  resetn,
  input  logic [motion_ctrl_pkg::word_bits-1:0] word_data_received,
  input  logic                                  word_received,
  output logic [motion_ctrl_pkg::word_bits-1:0] word_send_data,
  output logic                                  buffer_dtr,
  output logic                                  move_done,
  output logic [num_motors-1:0]                 step,
  output logic [num_motors-1:0]                 dir,
  output logic [num_motors-1:0]                 enable
);

  localparam int frac_bits = motion_ctrl_pkg::dda_frac_bits;

  logic                                             full;
  logic                                             slot_ready;
  logic                                             wr_en;
  logic [$clog2(buffer_size)-1:0]                   wr_slot;
  logic [$clog2(2*num_motors+2)-1:0]                wr_index;
  logic [motion_ctrl_pkg::word_bits-1:0]            wr_data;
  logic [num_motors-1:0]                            wr_dir;
  logic                                             commit;
  logic [motion_ctrl_pkg::divisor_bits-1:0]         clock_divisor;
  logic [motion_ctrl_pkg::duration_bits-1:0]        duration;
  logic [num_motors-1:0][frac_bits-1:0]             rate;
  logic [num_motors-1:0][frac_bits-1:0]             accel;
  logic [num_motors-1:0][motion_ctrl_pkg::position_bits-1:0] position;
  logic                                             dda_tick;
  logic                                             load;
  logic                                             executing;
  logic                                             release_slot;

  command_decoder #(.num_motors(num_motors), .buffer_size(buffer_size)) u_decoder (
    .CLK, .resetn, .word_data_received, .word_received, .full, .position,
    .word_send_data, .wr_en, .wr_slot, .wr_index, .wr_data, .wr_dir, .commit,
    .clock_divisor, .enable
  );

  // Directions of the read slot drive dir
  move_buffer #(.num_motors(num_motors), .buffer_size(buffer_size)) u_buffer (
    .CLK, .resetn, .wr_en, .wr_slot, .wr_index, .wr_data, .wr_dir, .commit, .release_slot,
    .full, .slot_ready, .buffer_dtr, .duration, .move_dir(dir), .rate, .accel
  );

  move_sequencer u_sequencer (
    .CLK, .resetn, .clock_divisor, .slot_ready, .duration,
    .dda_tick, .load, .executing, .release_slot, .move_done
  );

  for (genvar m = 0; m < num_motors; m++) begin : g_axis
    dda_axis u_axis (
      .CLK       (CLK),
      .resetn    (resetn),
      .dda_tick  (dda_tick),
      .load      (load),
      .executing (executing),
      .rate      (rate[m]),
      .accel     (accel[m]),
      .move_dir  (dir[m]),
      .step      (step[m]),
      .position  (position[m])
    );
  end

endmodule

// File: verif/motion_ctrl_tb.sv
`timescale 1ns/1ps
// Testbench for the step generator: host word driver, DDA step model and checks
module motion_ctrl_tb;

  localparam int num_motors   = 2;
  localparam int buffer_size  = 2;
  localparam int test_divisor = 4;
  localparam int move_timeout = 20000;  // Cycles per wait

  logic                                  CLK;
  logic                                  resetn;
  logic [motion_ctrl_pkg::word_bits-1:0] word_data_received;
  logic                                  word_received;
  logic [motion_ctrl_pkg::word_bits-1:0] word_send_data;
  logic                                  buffer_dtr;
  logic                                  move_done;
  logic [num_motors-1:0]                 step;
  logic [num_motors-1:0]                 dir;
  logic [num_motors-1:0]                 enable;

  logic [num_motors-1:0] dir_q [$];       // Directions of accepted moves, oldest first
  logic [63:0]           exp_q [$];       // Model step counts, axis m at bit 32*m
  logic [63:0]           done_q [$];      // Measured step counts of finished moves
  int                    interval_q [$];  // Cycles between axis 0 steps
  int unsigned           move_steps [num_motors];
  int                    exp_pos [num_motors];
  int                    cycle;
  int                    last_step0;

  motion_ctrl #(.num_motors(num_motors), .buffer_size(buffer_size)) DUT (
    .CLK, .resetn, .word_data_received, .word_received, .word_send_data,
    .buffer_dtr, .move_done, .step, .dir, .enable
  );

  always begin
    CLK = 1'b0;
    #50;
    CLK = 1'b1;
    #50;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else report_mismatch($sformatf("%s is %0h, expected %0h", what, got, exp));
  endtask

  // Steps are the 2**32 crossings of the sum of rate+k*accel over k = 1..dur
  function automatic int unsigned dda_steps(input int unsigned dur, input logic [31:0] rate,
                                            input logic [31:0] accel);
    logic [63:0] sum;
    logic [31:0] vel;
    sum = '0;
    for (int unsigned k = 1; k <= dur; k++) begin
      vel = rate + k * accel;
      sum += 64'(vel);
    end
    return 32'(sum >> motion_ctrl_pkg::dda_frac_bits);
  endfunction

  // Called and returns 1 ns after a rising edge
  task automatic send_word(input logic [63:0] data, output logic [63:0] resp);
    word_data_received = data;
    word_received      = 1'b1;
    repeat (2) @(posedge CLK);  // Response lands on the second edge
    #1;
    resp          = word_send_data;
    word_received = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
  endtask

  task automatic read_status(input int addr, output logic [63:0] resp);
    send_word({motion_ctrl_pkg::cmd_status_reg, 56'(addr)}, resp);
  endtask

  task automatic read_config(input int addr, output logic [63:0] resp);
    send_word({motion_ctrl_pkg::cmd_config_reg, 56'(addr)}, resp);
  endtask

  task automatic write_config(input int addr, input logic [63:0] data);
    logic [63:0] resp;
    send_word({motion_ctrl_pkg::cmd_config_reg,
               56'(addr) | (56'd1 << motion_ctrl_pkg::config_write_bit)}, resp);
    send_word(data, resp);
    check_value("response to config data word", resp, 0);
  endtask

  task automatic send_move(input logic [num_motors-1:0] dirs, input int unsigned dur,
                           input logic [31:0] rate0, accel0, rate1, accel1);
    logic [63:0] resp;
    send_word({motion_ctrl_pkg::cmd_coordinated_step, 56'(dirs)}, resp);
    send_word(64'(dur), resp);
    send_word(64'(rate0), resp);
    send_word(64'(accel0), resp);
    send_word(64'(rate1), resp);
    send_word(64'(accel1), resp);
    check_value("response to move word", resp, 0);
  endtask

  // Move the model expects to run
  task automatic queue_move(input logic [num_motors-1:0] dirs, input int unsigned dur,
                            input logic [31:0] rate0, accel0, rate1, accel1);
    int unsigned s0;
    int unsigned s1;
    s0 = dda_steps(dur, rate0, accel0);
    s1 = dda_steps(dur, rate1, accel1);
    dir_q.push_back(dirs);
    exp_q.push_back({s1, s0});
    exp_pos[0] += dirs[0] ? int'(s0) : -int'(s0);
    exp_pos[1] += dirs[1] ? int'(s1) : -int'(s1);
    send_move(dirs, dur, rate0, accel0, rate1, accel1);
  endtask

  task automatic check_moves(input int count);
    logic [63:0] got;
    logic [63:0] exp;
    int          waited;
    waited = 0;
    while (done_q.size() < count) begin
      @(posedge CLK);
      #1;
      waited++;
      if (waited > move_timeout) abort_run("Timeout while waiting for move_done");
    end
    repeat (count) begin
      got = done_q.pop_front();
      exp = exp_q.pop_front();
      check_value("axis 0 step count", got[31:0], exp[31:0]);
      check_value("axis 1 step count", got[63:32], exp[63:32]);
    end
  endtask

  // Single-cycle pulses
  assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else report_mismatch("move_done high for more than one cycle");
  assert property (@(posedge CLK) disable iff (resetn) (step & $past(step)) == '0)
    else report_mismatch("step high for more than one cycle");
  assert property (@(posedge CLK) disable iff (resetn) !word_received |=> $stable(enable))
    else report_mismatch("enable changed without a host word");

  always @(posedge CLK) begin
    cycle++;
    if (!resetn) begin
      for (int m = 0; m < num_motors; m++) begin
        if (step[m]) begin
          move_steps[m]++;
          if (dir_q.size() == 0) abort_run("Step pulse seen with no move queued");
          else if (dir[m] !== dir_q[0][m]) report_mismatch($sformatf("dir[%0d] wrong at step", m));
        end
      end
      if (step[0]) begin
        if (last_step0 != 0) interval_q.push_back(cycle - last_step0);
        last_step0 = cycle;
      end
      if (move_done) begin
        done_q.push_back({move_steps[1], move_steps[0]});
        move_steps = '{default: 0};
        if (dir_q.size() == 0) abort_run("move_done pulsed with no move queued");
        else void'(dir_q.pop_front());
      end
    end
  end

  initial begin
    logic [63:0]        resp;
    logic signed [63:0] pos;
    logic [31:0]        rate_a;
    logic [31:0]        rate_b;
    void'($urandom(32'h4bcf640c));
    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    repeat (10) @(posedge CLK);
    #1 resetn = 1'b0;
    @(posedge CLK);
    #1;
    check_value("step after reset", 64'(step), 0);
    check_value("move_done after reset", 64'(move_done), 0);
    check_value("enable after reset", 64'(enable), 0);
    check_value("buffer_dtr after reset", 64'(buffer_dtr), 1);
    read_status(motion_ctrl_pkg::status_version, resp);
    check_value("version word", resp, 64'(motion_ctrl_pkg::version_word));
    read_status(motion_ctrl_pkg::status_channel_info, resp);
    check_value("channel info", resp, {48'b0, 8'(motion_ctrl_pkg::dda_frac_bits), 8'(num_motors)});

    write_config(motion_ctrl_pkg::config_enable, 64'b11);
    check_value("enable output", 64'(enable), 64'b11);
    write_config(motion_ctrl_pkg::config_clocks, test_divisor);
    read_config(motion_ctrl_pkg::config_clocks, resp);
    check_value("clock divisor readback", resp, test_divisor);
    read_config(motion_ctrl_pkg::config_enable, resp);
    check_value("enable readback", resp, 64'b11);
    // Half a step per tick on axis 0 gives one step every two ticks
    queue_move(2'b11, 16, 32'h8000_0000, 0, 32'h4000_0000, 0);
    check_moves(1);
    check_value("axis 0 step intervals", interval_q.size(), 7);
    foreach (interval_q[i]) check_value("axis 0 step interval", interval_q[i], 2 * test_divisor);

    rate_a = $urandom;
    rate_b = $urandom;
    queue_move(2'b01, 20, rate_a, 0, rate_b, 0);
    check_moves(1);
    repeat (8 * test_divisor) @(posedge CLK);
    #1;
    check_value("extra move_done pulses", done_q.size(), 0);

    // Acceleration carries most of the steps, peak rate stays below one step per tick
    rate_a = $urandom >> 4;
    rate_b = $urandom >> 4;
    queue_move(2'b10, 24, rate_a, $urandom >> 5, rate_b, $urandom >> 5);
    check_moves(1);

    rate_a = $urandom;
    rate_b = $urandom;
    queue_move(2'b11, 40, rate_a, 0, rate_b, 0);
    check_value("buffer_dtr with one move", 64'(buffer_dtr), 1);
    rate_a = $urandom;
    rate_b = $urandom;
    queue_move(2'b00, 40, rate_a, 0, rate_b, 0);
    check_value("buffer_dtr with two moves", 64'(buffer_dtr), 0);
    send_move(2'b11, 40, 32'hffff_ffff, 0, 32'hffff_ffff, 0);  // Lost while full
    check_moves(2);
    repeat (60 * test_divisor) @(posedge CLK);
    #1;
    check_value("moves run after the lost one", done_q.size(), 0);
    check_value("buffer_dtr after moves", 64'(buffer_dtr), 1);

    for (int m = 0; m < num_motors; m++) begin
      read_status(motion_ctrl_pkg::status_position_start + m, resp);
      pos = exp_pos[m];
      check_value($sformatf("position of motor %0d", m), resp, pos);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: motion_ctrl.f
source/motion_ctrl_pkg.sv
source/dda_axis.sv
source/move_sequencer.sv
source/move_buffer.sv
source/command_decoder.sv
source/motion_ctrl.sv
verif/motion_ctrl_tb.sv

// File: Bender.yml
package:
  name: motion_ctrl

sources:
  - source/motion_ctrl_pkg.sv
  - source/dda_axis.sv
  - source/move_sequencer.sv
  - source/move_buffer.sv
  - source/command_decoder.sv
  - source/motion_ctrl.sv
  - target: simulation
    files:
      - verif/motion_ctrl_tb.sv
